//--- verilog/riscv_alu_ops_pkg.sv
/* RISC-V ISA encodings for the integer register-register and
   register-immediate ALU group */
package riscv_alu_ops_pkg;

    // funct3 field, bits 14:12 of OP and OP-IMM
    localparam logic [2:0] ALU_F3_ADD_SUB = 3'b000; // ADD, SUB, ADDI
    localparam logic [2:0] ALU_F3_SLL     = 3'b001; // SLL, SLLI
    localparam logic [2:0] ALU_F3_SLT     = 3'b010; // SLT, SLTI
    localparam logic [2:0] ALU_F3_SLTU    = 3'b011; // SLTU, SLTIU
    localparam logic [2:0] ALU_F3_XOR     = 3'b100; // XOR, XORI
    localparam logic [2:0] ALU_F3_SRL_SRA = 3'b101; // SRL, SRA and immediate forms
    localparam logic [2:0] ALU_F3_OR      = 3'b110; // OR, ORI
    localparam logic [2:0] ALU_F3_AND     = 3'b111; // AND, ANDI

    // Instruction bit that picks SUB over ADD and SRA over SRL
    // Lives in funct7 for R-type, in imm[10] for the shift immediates
    localparam int ALT_BIT = 30;

endpackage

//--- verilog/alu_unit_pkg.sv
/* Execution unit side types and default sizes for the ALU */
package alu_unit_pkg;

    // Operand width, 32 for RV32, 64 also supported
    localparam int DEFAULT_XLEN = 32;

    // Width of the instruction id carried to writeback
    localparam int DEFAULT_ID_W = 3;

    // What goes into the first adder input
    // Logic ops ride the adder carry chain with a zero second input
    typedef enum logic [1:0] {
        ALU_LOGIC_XOR = 2'b00, // a ^ b
        ALU_LOGIC_OR  = 2'b01, // a | b
        ALU_LOGIC_AND = 2'b10, // a & b
        ALU_LOGIC_ADD = 2'b11  // Plain add or subtract
    } logic_op_t;

endpackage

//--- verilog/alu_decode.sv
/* ALU decode: maps funct3, the alternate bit and the immediate
   select onto adder, shifter and result-select controls */
`timescale 1ns/1ps

module alu_decode #(
    parameter int XLEN = 32
) (
    input  logic [2:0]                  fn3,
    input  logic                        alt_fn,
    input  logic                        use_imm,
    input  logic [XLEN-1:0]             rs1_data,
    input  logic [XLEN-1:0]             rs2_data,
    input  logic [XLEN-1:0]             imm,
    output logic [XLEN-1:0]             adder_a,
    output logic [XLEN-1:0]             adder_b,
    output alu_unit_pkg::logic_op_t     logic_op,
    output logic                        subtract,
    output logic                        unsigned_cmp,
    output logic [XLEN-1:0]             shifter_in,
    output logic [$clog2(XLEN)-1:0]     shift_amount,
    output logic                        arith,
    output logic                        lshift,
    output logic                        shifter_path,
    output logic                        slt_path
);

    localparam int SHAMT_W = $clog2(XLEN); // 5 for RV32, 6 for RV64

    logic [XLEN-1:0] op2; // Second operand after immediate select

    assign op2 = use_imm ? imm : rs2_data;

    // Both datapaths see rs1 as first operand
    assign adder_a    = rs1_data;
    assign adder_b    = op2;
    assign shifter_in = rs1_data;

    // Only the low bits of operand two count as shift amount
    assign shift_amount = op2[SHAMT_W-1:0];

    always_comb begin
        // Defaults give a plain add through the adder path
        logic_op     = alu_unit_pkg::ALU_LOGIC_ADD;
        subtract     = 1'b0;
        unsigned_cmp = 1'b0;
        arith        = 1'b0;
        lshift       = 1'b0;
        shifter_path = 1'b0;
        slt_path     = 1'b0;

        case (fn3)
            riscv_alu_ops_pkg::ALU_F3_ADD_SUB: begin
                // ADDI has no SUB form, alt bit ignored there
                subtract = alt_fn & ~use_imm;
            end
            riscv_alu_ops_pkg::ALU_F3_SLT: begin
                subtract = 1'b1; // Compare is a - b
                slt_path = 1'b1;
            end
            riscv_alu_ops_pkg::ALU_F3_SLTU: begin
                subtract     = 1'b1;
                unsigned_cmp = 1'b1; // Zero extend instead of sign extend
                slt_path     = 1'b1;
            end
            riscv_alu_ops_pkg::ALU_F3_XOR: logic_op = alu_unit_pkg::ALU_LOGIC_XOR;
            riscv_alu_ops_pkg::ALU_F3_OR:  logic_op = alu_unit_pkg::ALU_LOGIC_OR;
            riscv_alu_ops_pkg::ALU_F3_AND: logic_op = alu_unit_pkg::ALU_LOGIC_AND;
            riscv_alu_ops_pkg::ALU_F3_SLL: begin
                shifter_path = 1'b1;
                lshift       = 1'b1; // Left shift via bit reversal
            end
            riscv_alu_ops_pkg::ALU_F3_SRL_SRA: begin
                shifter_path = 1'b1;
                arith        = alt_fn; // SRA and SRAI fill with sign
            end
            default: begin
                // All eight codes listed, keeps the defaults
            end
        endcase
    end

endmodule

//--- verilog/alu_add_logic.sv
/* Adder with subtract and compare extension, also carrying the
   XOR, OR and AND ops through the same carry chain */
`timescale 1ns/1ps

module alu_add_logic #(
    parameter int XLEN = 32
) (
    input  logic [XLEN-1:0]         adder_a,
    input  logic [XLEN-1:0]         adder_b,
    input  alu_unit_pkg::logic_op_t logic_op,
    input  logic                    subtract,
    input  logic                    unsigned_cmp,
    output logic [XLEN:0]           add_result
);

    logic [XLEN:0]   ext_a;   // Operands one bit wider for the compare
    logic [XLEN:0]   ext_b;
    logic [XLEN:0]   in1;
    logic [XLEN:0]   in2;
    logic [XLEN+1:0] sum;     // Extra low bit injects the carry

    // Sign extend for signed compare, zero extend for SLTU
    assign ext_a = {adder_a[XLEN-1] & ~unsigned_cmp, adder_a};
    assign ext_b = {adder_b[XLEN-1] & ~unsigned_cmp, adder_b};

    always_comb begin
        case (logic_op)
            alu_unit_pkg::ALU_LOGIC_XOR: in1 = ext_a ^ ext_b;
            alu_unit_pkg::ALU_LOGIC_OR:  in1 = ext_a | ext_b;
            alu_unit_pkg::ALU_LOGIC_AND: in1 = ext_a & ext_b;
            default:                     in1 = ext_a; // Add or subtract
        endcase

        // Logic result passes through with nothing added
        case (logic_op)
            alu_unit_pkg::ALU_LOGIC_ADD: in2 = ext_b ^ {(XLEN+1){subtract}};
            default:                     in2 = '0;
        endcase
    end

    // Carry-in for two's complement subtract
    // subtract + subtract in the low bit carries exactly subtract upward
    assign sum = {in1, subtract} + {in2, subtract};

    // Top bit is the less-than answer for both compare kinds
    assign add_result = sum[XLEN+1:1];

endmodule

//--- verilog/barrel_shifter.sv
/* Logarithmic right shifter; left shifts by reversing bits around it,
   arithmetic fill for SRA */
`timescale 1ns/1ps

module barrel_shifter #(
    parameter int XLEN = 32
) (
    input  logic [XLEN-1:0]         shifter_in,
    input  logic [$clog2(XLEN)-1:0] shift_amount,
    input  logic                    arith,
    input  logic                    lshift,
    output logic [XLEN-1:0]         shift_result
);

    localparam int SHAMT_W = $clog2(XLEN);

    logic [XLEN-1:0] stage [SHAMT_W+1]; // stage[0] is the input after reversal
    logic            fill;

    function automatic logic [XLEN-1:0] bit_reverse(input logic [XLEN-1:0] v);
        logic [XLEN-1:0] r;
        for (int k = 0; k < XLEN; k++) begin
            r[k] = v[XLEN-1-k];
        end
        return r;
    endfunction

    // Sign fill only for SRA, lshift never sets arith
    assign fill = arith & shifter_in[XLEN-1];

    assign stage[0] = lshift ? bit_reverse(shifter_in) : shifter_in;

    // One stage per shift amount bit, 2**i positions each
    for (genvar i = 0; i < SHAMT_W; i++) begin : g_stage
        localparam int STEP = 2 ** i;

        assign stage[i+1] = shift_amount[i] ?
            {{STEP{fill}}, stage[i][XLEN-1:STEP]} : stage[i];
    end

    // Undo the reversal for left shifts
    assign shift_result = lshift ? bit_reverse(stage[SHAMT_W]) : stage[SHAMT_W];

endmodule

//--- verilog/alu_writeback.sv
/* ALU writeback: picks shifter or adder result, forms the SLT bit,
   registers result, id and done pulse */
`timescale 1ns/1ps

module alu_writeback #(
    parameter int XLEN = 32,
    parameter int ID_W = 3
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            issue_new_request,
    input  logic [ID_W-1:0] issue_id,
    input  logic            shifter_path,
    input  logic            slt_path,
    input  logic [XLEN:0]   add_result,
    input  logic [XLEN-1:0] shift_result,
    output logic            wb_done,
    output logic [ID_W-1:0] wb_id,
    output logic [XLEN-1:0] wb_rd
);

    logic [XLEN-1:0] result;

    always_comb begin
        result = shifter_path ? shift_result : add_result[XLEN-1:0];
        // SLT and SLTU return 0 or 1
        if (slt_path) begin
            result = '0;
            result[0] = add_result[XLEN]; // Sign of a - b after extension
        end
    end

    // Done pulses one cycle after each issue strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_done <= 1'b0;
        end else begin
            wb_done <= issue_new_request;
        end
    end

    // Payload held until the next request
    always_ff @(posedge clk) begin
        if (issue_new_request) begin
            wb_rd <= result;
            wb_id <= issue_id;
        end
    end

endmodule

//--- verilog/alu_unit.sv
/* Single-cycle integer ALU execution unit, decode feeding adder and
   shifter side by side, result registered in writeback */
`timescale 1ns/1ps

module alu_unit #(
    parameter int XLEN = alu_unit_pkg::DEFAULT_XLEN,
    parameter int ID_W = alu_unit_pkg::DEFAULT_ID_W
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            single_cycle_issue_possible,
    input  logic            issue_new_request,
    input  logic [ID_W-1:0] issue_id,
    input  logic [2:0]      fn3,
    input  logic            alt_fn,
    input  logic            use_imm,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic [XLEN-1:0] imm,
    output logic            issue_ready,
    output logic            wb_done,
    output logic [ID_W-1:0] wb_id,
    output logic [XLEN-1:0] wb_rd
);

    localparam int SHAMT_W = $clog2(XLEN);

    // Decode to adder
    logic [XLEN-1:0]         adder_a;
    logic [XLEN-1:0]         adder_b;
    alu_unit_pkg::logic_op_t logic_op;
    logic                    subtract;
    logic                    unsigned_cmp;
    // Decode to shifter
    logic [XLEN-1:0]         shifter_in;
    logic [SHAMT_W-1:0]      shift_amount;
    logic                    arith;
    logic                    lshift;
    // Result select and datapath outputs
    logic                    shifter_path;
    logic                    slt_path;
    logic [XLEN:0]           add_result;
    logic [XLEN-1:0]         shift_result;

    // Always ready when the pipeline can take a single-cycle op
    assign issue_ready = single_cycle_issue_possible;

    alu_decode #(.XLEN(XLEN)) decode_i (
        .fn3, .alt_fn, .use_imm, .rs1_data, .rs2_data, .imm,
        .adder_a, .adder_b, .logic_op, .subtract, .unsigned_cmp,
        .shifter_in, .shift_amount, .arith, .lshift,
        .shifter_path, .slt_path
    );

    alu_add_logic #(.XLEN(XLEN)) add_logic_i (
        .adder_a, .adder_b, .logic_op, .subtract, .unsigned_cmp,
        .add_result
    );

    barrel_shifter #(.XLEN(XLEN)) shifter_i (
        .shifter_in, .shift_amount, .arith, .lshift,
        .shift_result
    );

    alu_writeback #(.XLEN(XLEN), .ID_W(ID_W)) writeback_i (
        .clk, .rst, .issue_new_request, .issue_id,
        .shifter_path, .slt_path, .add_result, .shift_result,
        .wb_done, .wb_id, .wb_rd
    );

endmodule

//--- test/alu_unit_tb.sv
/* Testbench for the ALU execution unit: directed vectors from a file,
   then random instructions checked against a reference model */
`timescale 1ns/1ps

module alu_unit_tb;

    localparam int    XLEN       = 32;
    localparam int    ID_W       = 3;
    localparam int    NUM_RANDOM = 200;
    localparam string VEC_FILE   = "test/alu_vectors.txt";

    logic            clk;
    logic            rst;
    logic            single_cycle_issue_possible;
    logic            issue_new_request;
    logic [ID_W-1:0] issue_id;
    logic [2:0]      fn3;
    logic            alt_fn;
    logic            use_imm;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] imm;
    logic            issue_ready;
    logic            wb_done;
    logic [ID_W-1:0] wb_id;
    logic [XLEN-1:0] wb_rd;

    // Directed vectors, one entry per file line
    logic [2:0]      vec_fn3 [$];
    logic            vec_alt [$];
    logic            vec_sel [$];
    logic [XLEN-1:0] vec_rs1 [$];
    logic [XLEN-1:0] vec_rs2 [$];
    logic [XLEN-1:0] vec_imm [$];
    logic [XLEN-1:0] vec_exp [$];

    // Results in flight, oldest first
    logic [ID_W-1:0] exp_id_q [$];
    logic [XLEN-1:0] exp_rd_q [$];

    logic [31:0]     rng_state;
    logic [ID_W-1:0] next_id;
    logic            issued_last;   // Strobe taken at the last rising edge
    int              value_errors;
    int              timing_errors;
    int              ready_errors;
    int              vector_errors;
    int              cycle_count = 0;
    int              cycle_limit = 2 * NUM_RANDOM + 50; // Updated once vectors are read

    alu_unit #(.XLEN(XLEN), .ID_W(ID_W)) dut_i (
        .clk, .rst, .single_cycle_issue_possible, .issue_new_request, .issue_id,
        .fn3, .alt_fn, .use_imm, .rs1_data, .rs2_data, .imm,
        .issue_ready, .wb_done, .wb_id, .wb_rd
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    // Run limit, each instruction takes at most two cycles
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run still going after %0d cycles", cycle_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // RV32 integer ALU rules, operand two from imm or rs2
    function automatic logic [XLEN-1:0] model_result(input logic [2:0] f3, input logic alt,
            input logic sel, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b_reg,
            input logic [XLEN-1:0] b_imm);
        logic [XLEN-1:0] b;
        logic [4:0]      sh;
        logic [XLEN-1:0] r;
        b  = sel ? b_imm : b_reg;
        sh = b[4:0]; // Only five bits of the amount count
        case (f3)
            riscv_alu_ops_pkg::ALU_F3_ADD_SUB: r = (alt && !sel) ? a - b : a + b; // No SUBI
            riscv_alu_ops_pkg::ALU_F3_SLL:     r = a << sh;
            riscv_alu_ops_pkg::ALU_F3_SLT:     r = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            riscv_alu_ops_pkg::ALU_F3_SLTU:    r = {{(XLEN-1){1'b0}}, a < b};
            riscv_alu_ops_pkg::ALU_F3_XOR:     r = a ^ b;
            riscv_alu_ops_pkg::ALU_F3_SRL_SRA: begin
                if (alt) r = $signed(a) >>> sh; // Sign fill
                else     r = a >> sh;
            end
            riscv_alu_ops_pkg::ALU_F3_OR:      r = a | b;
            riscv_alu_ops_pkg::ALU_F3_AND:     r = a & b;
            default:                           r = '0;
        endcase
        return r;
    endfunction

    // Called on the falling edge, outputs settled since the rising edge
    task automatic check_writeback();
        logic [ID_W-1:0] want_id;
        logic [XLEN-1:0] want_rd;
        assert (wb_done === issued_last) else begin
            timing_errors++;
            $display("** Error at %0t ns: wb_done %b, expected %b after the issue strobe",
                     $time, wb_done, issued_last);
        end
        if (wb_done === 1'b1) begin
            assert (exp_id_q.size() != 0) else begin
                timing_errors++;
                $display("wb_done at %0t ns with no instruction outstanding", $time);
            end
            if (exp_id_q.size() != 0) begin
                want_id = exp_id_q.pop_front();
                want_rd = exp_rd_q.pop_front();
                assert (wb_id === want_id && wb_rd === want_rd) else begin
                    value_errors++;
                    $display("** Error at %0t ns: wb_id %0d wb_rd %h, expected id %0d result %h",
                             $time, wb_id, wb_rd, want_id, want_rd);
                end
            end
        end
    endtask

    // One clock: ready and strobe checked at the rise, writeback at the fall
    task automatic step_cycle();
        @(posedge clk);
        assert (issue_ready === single_cycle_issue_possible) else begin
            ready_errors++;
            $display("** Error at %0t ns: issue_ready %b, expected %b from the pipeline",
                     $time, issue_ready, single_cycle_issue_possible);
        end
        issued_last = issue_new_request & ~rst;
        @(negedge clk);
        check_writeback();
    endtask

    task automatic drive_op(input logic [2:0] f3, input logic alt, input logic sel,
            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b, input logic [XLEN-1:0] i,
            input logic [XLEN-1:0] expect_rd);
        issue_new_request = 1'b1;
        issue_id          = next_id;
        fn3               = f3;
        alt_fn            = alt;
        use_imm           = sel;
        rs1_data          = a;
        rs2_data          = b;
        imm               = i;
        exp_id_q.push_back(next_id);
        exp_rd_q.push_back(expect_rd);
        next_id = next_id + 1'b1; // Id wraps
    endtask

    initial begin
        int              fd;
        int              got;
        int              n;
        string           line;
        logic [2:0]      f3;
        logic            alt;
        logic            sel;
        logic            ready_now;
        logic            was_low;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] i;
        logic [XLEN-1:0] e;

        rst                         = 1'b1;
        single_cycle_issue_possible = 1'b0;
        issue_new_request           = 1'b0;
        issue_id                    = '0;
        fn3                         = '0;
        alt_fn                      = 1'b0;
        use_imm                     = 1'b0;
        rs1_data                    = '0;
        rs2_data                    = '0;
        imm                         = '0;
        rng_state     = 32'hca174020;
        next_id       = '0;
        issued_last   = 1'b0;
        value_errors  = 0;
        timing_errors = 0;
        ready_errors  = 0;
        vector_errors = 0;

        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            vector_errors++;
            $display("Could not open the vector file %s", VEC_FILE);
        end
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#") begin // Skip column notes
                got = $sscanf(line, "%h %h %h %h %h %h %h", f3, alt, sel, a, b, i, e);
                if (got == 7) begin
                    vec_fn3.push_back(f3);
                    vec_alt.push_back(alt);
                    vec_sel.push_back(sel);
                    vec_rs1.push_back(a);
                    vec_rs2.push_back(b);
                    vec_imm.push_back(i);
                    vec_exp.push_back(e);
                end
            end
        end
        if (fd != 0) $fclose(fd);
        if (fd != 0 && vec_fn3.size() == 0) begin
            vector_errors++;
            $display("The vector file holds no usable lines");
        end
        cycle_limit = 2 * (vec_fn3.size() + NUM_RANDOM) + 50;

        // Two cycles of reset, then one idle cycle with wb_done low
        step_cycle();
        step_cycle();
        rst = 1'b0;
        single_cycle_issue_possible = 1'b1;
        step_cycle();

        // Directed vectors back to back, ready held high
        for (int k = 0; k < vec_fn3.size(); k++) begin
            assert (model_result(vec_fn3[k], vec_alt[k], vec_sel[k], vec_rs1[k], vec_rs2[k],
                                 vec_imm[k]) === vec_exp[k]) else begin
                vector_errors++;
                $display("Vector %0d in the file disagrees with the reference model", k);
            end
            drive_op(vec_fn3[k], vec_alt[k], vec_sel[k], vec_rs1[k], vec_rs2[k], vec_imm[k],
                     vec_exp[k]);
            step_cycle();
        end

        // Random instructions, ready low about one cycle in four
        n       = 0;
        was_low = 1'b0;
        while (n < NUM_RANDOM) begin
            rng_state = xorshift32(rng_state);
            ready_now = was_low | (rng_state[31:30] != 2'b00); // Never low twice running
            was_low   = ~ready_now;
            single_cycle_issue_possible = ready_now;
            if (ready_now) begin
                f3        = rng_state[2:0];
                alt       = rng_state[3];
                sel       = rng_state[4];
                rng_state = xorshift32(rng_state);
                a         = rng_state;
                rng_state = xorshift32(rng_state);
                b         = rng_state;
                rng_state = xorshift32(rng_state);
                i         = {{20{rng_state[11]}}, rng_state[11:0]}; // I-type immediate
                drive_op(f3, alt, sel, a, b, i, model_result(f3, alt, sel, a, b, i));
                n++;
            end else begin
                issue_new_request = 1'b0;
            end
            step_cycle();
        end
        issue_new_request = 1'b0;

        // Drain, then one more cycle to see done drop
        while (exp_id_q.size() != 0) begin
            step_cycle();
        end
        step_cycle();

        $display("Errors: %0d value, %0d timing, %0d ready, %0d vector file",
                 value_errors, timing_errors, ready_errors, vector_errors);
        if (value_errors + timing_errors + ready_errors + vector_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- test/alu_vectors.txt
# Columns in hex: fn3 alt_fn use_imm rs1 rs2 imm expected
# fn3: 0 add/sub, 1 sll, 2 slt, 3 sltu, 4 xor, 5 srl/sra, 6 or, 7 and
0 0 0 00000005 00000007 00000000 0000000c
0 0 0 7fffffff 00000001 00000000 80000000
0 0 0 ffffffff 00000001 00000000 00000000
0 0 0 80000000 80000000 00000000 00000000
0 1 0 00000000 00000001 00000000 ffffffff
0 1 0 00000000 80000000 00000000 80000000
0 1 0 12345678 00000678 00000000 12345000
0 1 0 80000000 00000001 00000000 7fffffff
0 0 1 00000010 deadbeef fffffff0 00000000
0 1 1 00000010 00000003 00000005 00000015
0 1 1 7fffffff 00000000 00000001 80000000
4 0 0 ff00ff00 0f0f0f0f 00000000 f00ff00f
4 0 1 12345678 00000000 ffffffff edcba987
6 0 0 f0f0f0f0 0f0f0f0f 00000000 ffffffff
6 0 1 80000000 ffffffff 00000123 80000123
7 0 0 ff00ff00 0ff00ff0 00000000 0f000f00
7 0 1 deadbeef 00000000 000000ff 000000ef
2 0 0 80000000 00000001 00000000 00000001
2 0 0 00000001 80000000 00000000 00000000
2 0 0 ffffffff 00000000 00000000 00000001
2 0 0 00000005 00000005 00000000 00000000
2 0 1 fffffffe 00000000 ffffffff 00000001
2 0 0 7fffffff 80000000 00000000 00000000
3 0 0 80000000 00000001 00000000 00000000
3 0 0 00000001 80000000 00000000 00000001
3 0 0 00000000 ffffffff 00000000 00000001
3 0 1 00000005 00000000 ffffffff 00000001
3 0 0 ffffffff ffffffff 00000000 00000000
1 0 0 00000001 00000000 00000000 00000001
1 0 0 00000001 0000001f 00000000 80000000
1 0 0 81234567 00000001 00000000 02468ace
1 0 1 0000000f 00000000 00000024 000000f0
1 0 0 deadbeef 00000040 00000000 deadbeef
5 0 0 80000000 0000001f 00000000 00000001
5 0 0 80000000 00000001 00000000 40000000
5 0 0 deadbeef 00000000 00000000 deadbeef
5 0 0 f0000000 00000024 00000000 0f000000
5 1 0 80000000 00000001 00000000 c0000000
5 1 0 80000000 0000001f 00000000 ffffffff
5 1 0 7fffffff 0000001e 00000000 00000001
5 1 1 f0000000 00000000 00000404 ff000000
5 1 0 fffffff0 00000020 00000000 fffffff0

//--- sources.f
verilog/riscv_alu_ops_pkg.sv
verilog/alu_unit_pkg.sv
verilog/alu_decode.sv
verilog/alu_add_logic.sv
verilog/barrel_shifter.sv
verilog/alu_writeback.sv
verilog/alu_unit.sv
test/alu_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ALU unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=alu_unit_sim

verilator --binary --timing --assert -f sources.f --top-module alu_unit_tb \
    -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
    echo "Testbench reported failure, see $LOG"
    exit 1
fi

exit 0
